// File: stack_cpu.f
hw/stack_isa_pkg.sv
hw/stack_bus_pkg.sv
hw/stack_fetch_decode.sv
hw/stack_operand_stack.sv
hw/stack_mem_xfer.sv
hw/stack_execute.sv
hw/stack_data_ram.sv
hw/stack_apb_host.sv
hw/stack_cpu_top.sv
verification/stack_cpu_checks.sv
verification/stack_cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, keep the output in sim.log and scan it for the fail message.
# A simulator that exits abnormally also counts as a failure.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f stack_cpu.f --top-module stack_cpu_tb \
    -o stack_cpu_sim &&
{ ./obj_dir/stack_cpu_sim > sim.log 2>&1 || echo "Test FAILED" >> sim.log; } &&
cat sim.log &&
! grep -q "Test FAILED" sim.log ||
{ echo "Simulation failed, see sim.log"; exit 1; }

// File: verification/stack_cpu_tb.sv
`timescale 1ns/10ps

module stack_cpu_tb import stack_isa_pkg::*, stack_bus_pkg::*; ();

    localparam int clk_period      = 8;
    localparam int n_instr         = 3 + 4 * 5 + 5 + 18 + 2 + 18;   // Over all programs below
    localparam int watchdog_cycles = 200 * n_instr + 2000;

    logic       clk = 1'b0;
    logic       rstn;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       exp_slverr;
    logic [3:0] exp_status;
    logic [3:0] status_mask;
    int         errors;
    instr_t     prog [$];

    stack_cpu_top i_stack_cpu_top (.clk, .rstn, .apb_req, .apb_rsp);

    stack_cpu_checks i_checks (
        .clk, .rstn, .apb_req, .apb_rsp, .exp_slverr, .exp_status, .status_mask, .errors
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run hung", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

    function automatic instr_t ins(opcode_e op, logic [7:0] operand);
        instr_t i;
        i.opcode  = op;
        i.operand = operand;
        return i;
    endfunction

    function automatic logic [11:0] data_addr(logic [7:0] a);
        return data_base | {2'b00, a, 2'b00};
    endfunction

    function automatic logic [7:0] fill_value(logic [7:0] a);
        return a * 8'd37 + 8'd11;
    endfunction

    // Result is next op top, next being the older entry
    function automatic logic [7:0] alu_expect(opcode_e op, logic [7:0] nxt, logic [7:0] tp);
        case (op)
            op_add:  return nxt + tp;
            op_sub:  return nxt - tp;
            op_and:  return nxt & tp;
            default: return nxt ^ tp;
        endcase
    endfunction

    task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                            input logic slverr, output logic [31:0] rdata);
        logic done;
        @(posedge clk);
        #1;
        exp_slverr      = slverr;
        apb_req.paddr   = addr;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        do begin
            #2;   // Mid cycle
            done  = apb_rsp.pready;
            rdata = apb_rsp.prdata;
            @(posedge clk);
            #1;
        end while (!done);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(logic [11:0] addr, logic [31:0] wdata, logic slverr);
        logic [31:0] ignored;
        apb_xfer(1'b1, addr, wdata, slverr, ignored);
        if (!slverr && addr[11:10] == data_base[11:10])
            i_checks.expect_data(addr[9:2], wdata[7:0]);
    endtask

    task automatic check_status(logic [3:0] value);
        logic [31:0] rd;
        exp_status  = value;
        status_mask = 4'hf;
        apb_xfer(1'b0, status_addr, 32'd0, 1'b0, rd);
    endtask

    task automatic wait_halt();
        logic [31:0] status;
        status_mask = 4'h0;
        do begin
            apb_xfer(1'b0, status_addr, 32'd0, 1'b0, status);
        end while (!status[1]);
    endtask

    task automatic start_program();
        foreach (prog[i])
            apb_write(prog_base | 12'(i * 4), 32'(prog[i]), 1'b0);
        prog.delete();
        apb_write(ctrl_addr, 32'd1, 1'b0);
    endtask

    task automatic run_program();
        start_program();
        wait_halt();
    endtask

    task automatic alu_case(opcode_e op);
        logic [7:0]  x;
        logic [7:0]  va;
        logic [7:0]  vb;
        logic [31:0] rd;
        x  = 8'($urandom);
        va = 8'($urandom);
        vb = 8'($urandom);
        apb_write(data_addr(x), 32'(va), 1'b0);
        apb_write(data_addr(x + 8'd1), 32'(vb), 1'b0);
        prog.push_back(ins(op_pushm, x));
        prog.push_back(ins(op_pushm, x + 8'd1));
        prog.push_back(ins(op, 8'h00));
        prog.push_back(ins(op_popm, x + 8'd2));
        prog.push_back(ins(op_halt, 8'h00));
        run_program();
        i_checks.expect_data(x + 8'd2, alu_expect(op, va, vb));
        apb_xfer(1'b0, data_addr(x + 8'd2), 32'd0, 1'b0, rd);
    endtask

    task automatic overflow_program();
        for (int i = 0; i < stack_depth + 1; i++)
            prog.push_back(ins(op_pushc, 8'($urandom)));
        prog.push_back(ins(op_halt, 8'h00));
    endtask

    initial begin
        logic [7:0]  k;
        logic [7:0]  x;
        logic [7:0]  va;
        logic [31:0] rd;
        void'($urandom(32'h979052bc));
        rstn        = 1'b0;
        apb_req     = '0;
        exp_slverr  = 1'b0;
        exp_status  = 4'h0;
        status_mask = 4'h0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        check_status(4'b0000);
        for (int a = 0; a < 2**addr_w; a++)
            apb_write(data_addr(8'(a)), 32'(fill_value(8'(a))), 1'b0);
        apb_xfer(1'b0, data_addr(8'($urandom)), 32'd0, 1'b0, rd);

        k = 8'($urandom);
        x = 8'($urandom);
        prog.push_back(ins(op_pushc, k));
        prog.push_back(ins(op_popm, x));
        prog.push_back(ins(op_halt, 8'h00));
        run_program();
        i_checks.expect_data(x, k);
        check_status(4'b0010);
        apb_xfer(1'b0, data_addr(x), 32'd0, 1'b0, rd);

        alu_case(op_add);
        alu_case(op_sub);
        alu_case(op_and);
        alu_case(op_xor);

        x  = 8'($urandom);
        va = 8'($urandom);
        apb_write(data_addr(x), 32'(va), 1'b0);
        prog.push_back(ins(op_pushm, x));
        prog.push_back(ins(op_dup, 8'h00));
        prog.push_back(ins(op_add, 8'h00));
        prog.push_back(ins(op_popm, x + 8'd1));
        prog.push_back(ins(op_halt, 8'h00));
        run_program();
        i_checks.expect_data(x + 8'd1, va + va);
        apb_xfer(1'b0, data_addr(x + 8'd1), 32'd0, 1'b0, rd);

        overflow_program();
        run_program();
        check_status(4'b0110);
        x = 8'($urandom);
        prog.push_back(ins(op_popm, x));
        prog.push_back(ins(op_halt, 8'h00));
        run_program();
        check_status(4'b1010);
        apb_write(data_addr(x), 32'(fill_value(x)), 1'b0);   // Back to a known word

        overflow_program();
        start_program();
        exp_status  = 4'b0001;
        status_mask = 4'b0001;
        apb_xfer(1'b0, status_addr, 32'd0, 1'b0, rd);
        apb_write(prog_base, 32'(ins(op_halt, 8'h00)), 1'b1);
        apb_write(data_addr(8'($urandom)), 32'($urandom), 1'b1);
        wait_halt();
        check_status(4'b0110);
        apb_xfer(1'b0, 12'h008, 32'd0, 1'b1, rd);
        apb_xfer(1'b0, 12'hc00, 32'd0, 1'b1, rd);

        repeat (2) @(posedge clk);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: verification/stack_cpu_checks.sv
`timescale 1ns/10ps

module stack_cpu_checks import stack_isa_pkg::*, stack_bus_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  apb_req_t   apb_req,
    input  apb_rsp_t   apb_rsp,
    input  logic       exp_slverr,
    input  logic [3:0] exp_status,
    input  logic [3:0] status_mask,
    output int         errors
);

    logic [data_w-1:0] model [2**addr_w];   // Expected data memory contents
    int                err_cnt = 0;
    logic              access;
    logic              status_rd;
    logic              data_rd;

    assign errors    = err_cnt;
    assign access    = apb_req.psel && apb_req.penable;
    assign status_rd = access && !apb_req.pwrite && apb_req.paddr == status_addr;
    assign data_rd   = access && !apb_req.pwrite && !exp_slverr &&
                       apb_req.paddr[11:10] == data_base[11:10];

    task automatic expect_data(logic [addr_w-1:0] addr, logic [data_w-1:0] value);
        model[addr] = value;
    endtask

    task automatic log_error(string name, logic [31:0] exp_val, logic [31:0] act_val);
        err_cnt++;
        $display("[ERROR] t=%0d ns %s expected %0h actual %0h", $time, name, exp_val, act_val);
    endtask

    assert property (@(posedge clk) disable iff (!rstn) access |-> apb_rsp.pready)
        else log_error("pready", 32'd1, 32'($sampled(apb_rsp.pready)));

    assert property (@(posedge clk) disable iff (!rstn) access |-> apb_rsp.pslverr == exp_slverr)
        else log_error("pslverr", 32'(exp_slverr), 32'($sampled(apb_rsp.pslverr)));

    // Only the bits under the mask are known at this point
    assert property (@(posedge clk) disable iff (!rstn)
        status_rd |-> (apb_rsp.prdata[3:0] & status_mask) == (exp_status & status_mask))
        else log_error("status", 32'(exp_status & status_mask),
                       32'($sampled(apb_rsp.prdata[3:0]) & status_mask));

    assert property (@(posedge clk) disable iff (!rstn)
        data_rd |-> apb_rsp.prdata[data_w-1:0] == model[apb_req.paddr[9:2]])
        else log_error("prdata", 32'(model[$sampled(apb_req.paddr[9:2])]),
                       32'($sampled(apb_rsp.prdata)));

endmodule

// File: hw/stack_cpu_top.sv
`timescale 1ns/10ps

module stack_cpu_top import stack_isa_pkg::*, stack_bus_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic                   start, halt, running, ready, overflow, underflow;
    logic                   host_prog_we, host_data_we;
    logic [prog_addr_w-1:0] host_prog_addr;
    instr_t                 host_prog_wdata;
    logic [addr_w-1:0]      host_data_addr;
    logic [data_w-1:0]      host_data_wdata, host_data_rdata;
    exec_op_t               slot;
    logic                   slot_valid;
    logic                   xfer_start, fin, xfer_busy;
    opcode_e                xfer_op;
    logic [data_w-1:0]      xfer_operand, top, next, rdata;
    mem_req_t               mem_req;
    logic                   e_push, e_pop, e_pop2, x_push, x_pop;
    logic [data_w-1:0]      e_data, x_data;

    stack_apb_host i_apb_host (
        .clk, .rstn, .apb_req, .running, .halt, .overflow, .underflow, .apb_rsp, .start,
        .host_prog_we, .host_prog_addr, .host_prog_wdata,
        .host_data_we, .host_data_addr, .host_data_wdata, .host_data_rdata
    );

    stack_fetch_decode i_fetch_decode (
        .clk, .rstn, .start, .halt, .host_prog_we, .host_prog_addr, .host_prog_wdata,
        .ready, .slot, .slot_valid, .running
    );

    stack_execute i_execute (
        .clk, .rstn, .slot, .slot_valid, .top, .next, .fin, .busy(xfer_busy), .ready,
        .xfer_start, .xfer_op, .xfer_operand, .stk_push(e_push), .stk_pop(e_pop),
        .stk_pop2(e_pop2), .stk_data(e_data), .halt
    );

    stack_mem_xfer i_mem_xfer (
        .clk, .rstn, .xfer_start, .xfer_op, .xfer_operand, .top, .rdata, .mem_req,
        .stk_push(x_push), .stk_pop(x_pop), .stk_data(x_data), .fin, .busy(xfer_busy)
    );

    // Transfer unit owns the stack from start to fin
    stack_operand_stack i_operand_stack (
        .clk, .rstn, .clear(start),
        .push(xfer_busy ? x_push : e_push), .pop(xfer_busy ? x_pop : e_pop),
        .pop2(xfer_busy ? 1'b0 : e_pop2), .push_data(xfer_busy ? x_data : e_data),
        .top, .next, .overflow, .underflow
    );

    stack_data_ram i_data_ram (
        .clk, .core_req(mem_req), .host_we(host_data_we), .host_addr(host_data_addr),
        .host_wdata(host_data_wdata), .rdata, .host_rdata(host_data_rdata)
    );

endmodule

// File: hw/stack_apb_host.sv
`timescale 1ns/10ps

module stack_apb_host import stack_isa_pkg::*, stack_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  apb_req_t               apb_req,
    input  logic                   running,
    input  logic                   halt,
    input  logic                   overflow,
    input  logic                   underflow,
    output apb_rsp_t               apb_rsp,
    output logic                   start,
    output logic                   host_prog_we,
    output logic [prog_addr_w-1:0] host_prog_addr,
    output instr_t                 host_prog_wdata,
    output logic                   host_data_we,
    output logic [addr_w-1:0]      host_data_addr,
    output logic [data_w-1:0]      host_data_wdata,
    input  logic [data_w-1:0]      host_data_rdata
);

    logic access;
    logic wr;
    logic is_ctrl;
    logic is_status;
    logic is_prog;
    logic is_data;
    logic halted;

    assign access    = apb_req.psel && apb_req.penable;
    assign wr        = access && apb_req.pwrite;
    assign is_ctrl   = apb_req.paddr == ctrl_addr;
    assign is_status = apb_req.paddr == status_addr;
    assign is_prog   = apb_req.paddr[11:10] == prog_base[11:10];
    assign is_data   = apb_req.paddr[11:10] == data_base[11:10];

    assign start = wr && is_ctrl && apb_req.pwdata[0];

    assign host_prog_we    = wr && is_prog && !running;
    assign host_prog_addr  = apb_req.paddr[9:2];
    assign host_prog_wdata = instr_t'(apb_req.pwdata[$bits(instr_t)-1:0]);
    assign host_data_we    = wr && is_data && !running;
    assign host_data_addr  = apb_req.paddr[9:2];
    assign host_data_wdata = apb_req.pwdata[data_w-1:0];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            halted <= 1'b0;
        else if (start)
            halted <= 1'b0;
        else if (halt)
            halted <= 1'b1;
    end

    always_comb begin
        apb_rsp        = '0;
        apb_rsp.pready = 1'b1;   // Zero-wait
        if (access) begin
            if (is_status)
                apb_rsp.prdata = {{(apb_data_w-4){1'b0}}, underflow, overflow, halted, running};
            else if (is_data)
                apb_rsp.prdata = apb_data_w'(host_data_rdata);
            apb_rsp.pslverr = !(is_ctrl || is_status || is_prog || is_data) ||
                              (wr && running && (is_prog || is_data));
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) apb_req.penable |-> apb_req.psel)
        else $error("penable without psel");

endmodule

// File: hw/stack_data_ram.sv
`timescale 1ns/10ps

module stack_data_ram import stack_isa_pkg::*, stack_bus_pkg::*; (
    input  logic              clk,
    input  mem_req_t          core_req,
    input  logic              host_we,
    input  logic [addr_w-1:0] host_addr,
    input  logic [data_w-1:0] host_wdata,
    output logic [data_w-1:0] rdata,
    output logic [data_w-1:0] host_rdata
);

    logic [data_w-1:0] mem [2**addr_w];

    always_ff @(posedge clk) begin
        if (core_req.wen)
            mem[core_req.addr] <= core_req.wdata;
        else if (host_we)
            mem[host_addr] <= host_wdata;   // Host only writes while the core is stopped
        if (core_req.ren)
            rdata <= mem[core_req.addr];
    end

    assign host_rdata = mem[host_addr];

endmodule

// File: hw/stack_execute.sv
`timescale 1ns/10ps

module stack_execute import stack_isa_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  exec_op_t          slot,
    input  logic              slot_valid,
    input  logic [data_w-1:0] top,
    input  logic [data_w-1:0] next,
    input  logic              fin,
    input  logic              busy,
    output logic              ready,
    output logic              xfer_start,
    output opcode_e           xfer_op,
    output logic [data_w-1:0] xfer_operand,
    output logic              stk_push,
    output logic              stk_pop,
    output logic              stk_pop2,
    output logic [data_w-1:0] stk_data,
    output logic              halt
);

    logic              accept;
    logic              local_op;
    logic              pending;   // Between xfer_start and fin
    logic [data_w-1:0] alu_res;

    assign ready    = !pending;
    assign accept   = slot_valid && ready;
    assign local_op = accept && !slot.is_mem;

    always_comb begin
        case (slot.opcode)
            op_add:  alu_res = next + top;
            op_sub:  alu_res = next - top;
            op_and:  alu_res = next & top;
            op_xor:  alu_res = next ^ top;
            op_dup:  alu_res = top;
            default: alu_res = '0;
        endcase
    end

    // ALU ops and DUP go straight to the stack this cycle
    assign stk_push = local_op && slot.pushes;
    assign stk_pop  = local_op && slot.pops == 2'd1;
    assign stk_pop2 = local_op && slot.pops == 2'd2;
    assign stk_data = alu_res;

    assign xfer_start   = accept && slot.is_mem;
    assign xfer_op      = slot.opcode;
    assign xfer_operand = slot.operand;

    assign halt = accept && slot.opcode == op_halt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            pending <= 1'b0;
        else if (xfer_start)
            pending <= 1'b1;
        else if (fin)
            pending <= 1'b0;
    end

    // Transfer unit holds the stack for as long as execute waits
    assert property (@(posedge clk) disable iff (!rstn) pending |-> busy)
        else $error("execute waiting on an idle transfer unit");

endmodule

// File: hw/stack_mem_xfer.sv
`timescale 1ns/10ps

module stack_mem_xfer import stack_isa_pkg::*, stack_bus_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              xfer_start,
    input  opcode_e           xfer_op,
    input  logic [data_w-1:0] xfer_operand,
    input  logic [data_w-1:0] top,
    input  logic [data_w-1:0] rdata,
    output mem_req_t          mem_req,
    output logic              stk_push,
    output logic              stk_pop,
    output logic [data_w-1:0] stk_data,
    output logic              fin,
    output logic              busy
);

    typedef enum logic [2:0] {
        st_idle, st_load, st_push, st_push_d, st_pop, st_pop_d, st_store
    } xfer_state_e;

    xfer_state_e       state;
    opcode_e           op_q;
    logic [data_w-1:0] operand_q;   // Constant or memory address
    logic [data_w-1:0] data_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (xfer_start) begin
                        case (xfer_op)
                            op_pushc: state <= st_push;
                            op_pushm: state <= st_load;
                            op_popm:  state <= st_pop;
                            default:  state <= st_idle;
                        endcase
                    end
                end
                st_load:   state <= st_push;    // RAM data shows up next cycle
                st_push:   state <= st_push_d;
                st_pop:    state <= st_pop_d;
                st_pop_d:  state <= st_store;
                default:   state <= st_idle;    // PUSH_D and STORE finish here
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && xfer_start) begin
            op_q      <= xfer_op;
            operand_q <= xfer_operand;
        end
        if (state == st_push)
            data_q <= (op_q == op_pushc) ? operand_q : rdata;
        if (state == st_pop)
            data_q <= top;   // Top before the pop lands
    end

    assign stk_push = state == st_push_d;
    assign stk_pop  = state == st_pop;
    assign stk_data = data_q;
    assign fin      = state == st_push_d || state == st_store;
    assign busy     = state != st_idle;

    assign mem_req.ren   = state == st_load;
    assign mem_req.wen   = state == st_store;
    assign mem_req.addr  = (mem_req.ren || mem_req.wen) ? operand_q : '0;
    assign mem_req.wdata = mem_req.wen ? data_q : '0;

    // Two cycles from start to fin for PUSHC and three for PUSHM and POPM
    assert property (@(posedge clk) disable iff (!rstn)
        fin |-> $past(xfer_start && xfer_op == op_pushc, 2) ||
                $past(xfer_start && xfer_op != op_pushc, 3))
        else $error("fin out of step with the transfer start");

    // Execute must wait for fin before starting another transfer
    assert property (@(posedge clk) disable iff (!rstn) xfer_start |-> !busy)
        else $error("transfer started while busy");

endmodule

// File: hw/stack_operand_stack.sv
`timescale 1ns/10ps

module stack_operand_stack import stack_isa_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              clear,
    input  logic              push,
    input  logic              pop,
    input  logic              pop2,
    input  logic [data_w-1:0] push_data,
    output logic [data_w-1:0] top,
    output logic [data_w-1:0] next,
    output logic              overflow,
    output logic              underflow
);

    logic [data_w-1:0] regs [stack_depth];
    logic [cnt_w-1:0]  cnt;
    logic [cnt_w-1:0]  n_pop;
    logic [cnt_w-1:0]  cnt_popped;   // Depth after this cycle's pops
    logic              short;
    logic              full;

    assign n_pop      = pop2 ? cnt_w'(2) : (pop ? cnt_w'(1) : '0);
    assign short      = n_pop > cnt;
    assign cnt_popped = short ? '0 : cnt - n_pop;
    assign full       = cnt_popped == cnt_w'(stack_depth);

    // Empty entries read as zero
    assign top  = (cnt > cnt_w'(0)) ? regs[sp_w'(cnt - cnt_w'(1))] : '0;
    assign next = (cnt > cnt_w'(1)) ? regs[sp_w'(cnt - cnt_w'(2))] : '0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt       <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else if (clear) begin
            cnt       <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (short)
                underflow <= 1'b1;
            if (push && full)
                overflow <= 1'b1;
            cnt <= (push && !full) ? cnt_popped + cnt_w'(1) : cnt_popped;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full && !clear)
            regs[cnt_popped[sp_w-1:0]] <= push_data;   // Pop and push share one update
    end

    // Pushed value reads back as top even when two entries go in the same update
    assert property (@(posedge clk) disable iff (!rstn)
        push && !full && !clear |=> top == $past(push_data))
        else $error("pushed value not on top of stack");

endmodule

// File: hw/stack_fetch_decode.sv
`timescale 1ns/10ps

module stack_fetch_decode import stack_isa_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    input  logic                   halt,
    input  logic                   host_prog_we,
    input  logic [prog_addr_w-1:0] host_prog_addr,
    input  instr_t                 host_prog_wdata,
    input  logic                   ready,
    output exec_op_t               slot,
    output logic                   slot_valid,
    output logic                   running
);

    instr_t                 prog_mem [2**prog_addr_w];
    logic [prog_addr_w-1:0] pc;
    logic                   fill;

    function automatic exec_op_t decode(instr_t ins);
        exec_op_t d;
        d.opcode  = ins.opcode;
        d.operand = ins.operand;
        d.is_mem  = 1'b0;
        d.pops    = 2'd0;
        d.pushes  = 1'b0;
        case (ins.opcode)
            op_pushc, op_pushm: begin
                d.is_mem = 1'b1;
                d.pushes = 1'b1;
            end
            op_popm: begin
                d.is_mem = 1'b1;
                d.pops   = 2'd1;
            end
            op_add, op_sub, op_and, op_xor: begin
                d.pops   = 2'd2;
                d.pushes = 1'b1;
            end
            op_dup:  d.pushes = 1'b1;
            default: d.pops   = 2'd0;   // HALT and unknown codes touch nothing
        endcase
        return d;
    endfunction

    // Refill when the slot is empty or leaving this cycle
    assign fill = running && !halt && (!slot_valid || ready);

    always_ff @(posedge clk) begin
        if (host_prog_we)
            prog_mem[host_prog_addr] <= host_prog_wdata;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc         <= '0;
            running    <= 1'b0;
            slot_valid <= 1'b0;
        end else if (start) begin
            pc         <= '0;
            running    <= 1'b1;
            slot_valid <= 1'b0;
        end else if (halt) begin
            running    <= 1'b0;
            slot_valid <= 1'b0;   // Drop whatever was prefetched past HALT
        end else if (fill) begin
            pc         <= pc + 1'b1;
            slot_valid <= 1'b1;
        end else if (slot_valid && ready) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill && !start)
            slot <= decode(prog_mem[pc]);
    end

    // Host side must hold program writes off while the core runs
    assert property (@(posedge clk) disable iff (!rstn) !(host_prog_we && running))
        else $error("program memory written while running");

endmodule

// File: hw/stack_bus_pkg.sv
package stack_bus_pkg;

    import stack_isa_pkg::*;

    localparam int apb_addr_w = 12;
    localparam int apb_data_w = 32;

    typedef struct packed {
        logic [apb_addr_w-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [apb_data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [apb_data_w-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // Core side of the data memory
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              ren;
        logic              wen;
    } mem_req_t;

    localparam logic [apb_addr_w-1:0] ctrl_addr   = 12'h000;
    localparam logic [apb_addr_w-1:0] status_addr = 12'h004;
    localparam logic [apb_addr_w-1:0] prog_base   = 12'h400;
    localparam logic [apb_addr_w-1:0] data_base   = 12'h800;

endpackage

// File: hw/stack_isa_pkg.sv
package stack_isa_pkg;

    localparam int data_w      = 8;
    localparam int addr_w      = 8;
    localparam int prog_addr_w = 8;
    localparam int stack_depth = 16;
    localparam int sp_w        = $clog2(stack_depth);
    localparam int cnt_w       = $clog2(stack_depth + 1);   // Counts 0 to stack_depth

    // Memory ops take the low codes so they can be spotted like the old control bus
    typedef enum logic [3:0] {
        op_pushc = 4'h0,
        op_pushm = 4'h1,
        op_popm  = 4'h2,
        op_add   = 4'h3,
        op_sub   = 4'h4,
        op_and   = 4'h5,
        op_xor   = 4'h6,
        op_dup   = 4'h7,
        op_halt  = 4'hf
    } opcode_e;

    // Program memory word
    typedef struct packed {
        opcode_e             opcode;
        logic [data_w-1:0]   operand;   // Constant or data address
    } instr_t;

    // Decoded slot between fetch/decode and execute
    typedef struct packed {
        opcode_e             opcode;
        logic [data_w-1:0]   operand;
        logic                is_mem;    // Handled by the transfer unit
        logic [1:0]          pops;
        logic                pushes;
    } exec_op_t;

endpackage
